/* spi_sampler.f */
hw/spi_sampler_pkg.sv
hw/wb_regs_pkg.sv
hw/spi_byte_if.sv
hw/spi_master.sv
hw/sample_fifo.sv
hw/sampler_ctrl.sv
hw/wb_regs.sv
hw/spi_sampler_top.sv
testbench/spi_sampler_asserts.sv
testbench/tb_spi_sampler.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_spi_sampler
RTL_TOP   ?= spi_sampler_top
FILELIST  ?= spi_sampler.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RTL_FILES := $(shell grep '^hw/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_spi_sampler.sv */
`timescale 1ns/1ps

module tb_spi_sampler import wb_regs_pkg::*; ();

    localparam int WB_TIMEOUT    = 16;
    localparam int LEVEL_POLLS   = 500;
    localparam int FRAME_TIMEOUT = 6000;
    localparam int IDLE_TIMEOUT  = 400;

    logic             clk;
    logic             i_arst_n;
    logic             i_wb_cyc;
    logic             i_wb_stb;
    logic             i_wb_we;
    logic [WB_AW-1:0] i_wb_adr;
    logic [WB_DW-1:0] i_wb_dat;
    logic [WB_DW-1:0] o_wb_dat;
    logic             o_wb_ack;
    logic             o_sclk;
    logic             o_mosi;
    logic             o_cs_n;
    logic             i_miso;

    // Scoreboard state shared by the SPI slave model and the tests
    logic [23:0]      exp_q[$];
    logic [7:0]       model_seq;
    logic [7:0]       model_cmd;
    int               frame_cnt;
    int               errors;
    int               tests_run;
    int               tests_failed;

    spi_sampler_top #(
        .CLKS_PER_HALF_BIT(2),
        .FIFO_DEPTH       (8)
    ) DUT (
        .clk     (clk),
        .i_arst_n(i_arst_n),
        .i_wb_cyc(i_wb_cyc),
        .i_wb_stb(i_wb_stb),
        .i_wb_we (i_wb_we),
        .i_wb_adr(i_wb_adr),
        .i_wb_dat(i_wb_dat),
        .o_wb_dat(o_wb_dat),
        .o_wb_ack(o_wb_ack),
        .o_sclk  (o_sclk),
        .o_mosi  (o_mosi),
        .o_cs_n  (o_cs_n),
        .i_miso  (i_miso)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    // Mode 0 SPI slave model with edges found at clock granularity
    initial begin
        logic        prev_cs;
        logic        prev_sclk;
        logic [15:0] frame_word;
        logic [15:0] mosi_bits;
        int          bit_idx;
        i_miso    = 1'b0;
        prev_cs   = 1'b1;
        prev_sclk = 1'b0;
        bit_idx   = 0;
        forever begin
            @(posedge clk);
            #1;
            if (prev_cs && !o_cs_n) begin
                frame_word = 16'($urandom);
                exp_q.push_back({model_seq, frame_word});
                model_seq++;
                frame_cnt++;
                bit_idx   = 0;
                mosi_bits = '0;
                i_miso    = frame_word[15];
            end
            // Master samples on the rising SCLK edge
            if (!o_cs_n && !prev_sclk && o_sclk) begin
                mosi_bits = {mosi_bits[14:0], o_mosi};
            end
            // Next MISO bit after each falling edge
            if (!o_cs_n && prev_sclk && !o_sclk) begin
                bit_idx++;
                if (bit_idx < 16) begin
                    i_miso = frame_word[15-bit_idx];
                end
            end
            if (!prev_cs && o_cs_n) begin
                check_value("o_mosi", 32'(mosi_bits), {16'h0, model_cmd, 8'h00});
                i_miso = 1'b0;
            end
            prev_cs   = o_cs_n;
            prev_sclk = o_sclk;
        end
    end

    // Bus tasks are entered 1 ns after a rising edge
    task automatic write_reg(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat);
        int n;
        n        = 0;
        i_wb_adr = adr;
        i_wb_dat = dat;
        i_wb_we  = 1'b1;
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!o_wb_ack && n < WB_TIMEOUT);
        if (!o_wb_ack) begin
            $display("write to address %0h got no ack within %0d clocks", adr, WB_TIMEOUT);
            errors++;
        end
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
    endtask

    task automatic read_reg(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] dat);
        int n;
        n        = 0;
        i_wb_adr = adr;
        i_wb_we  = 1'b0;
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!o_wb_ack && n < WB_TIMEOUT);
        dat = o_wb_dat;
        if (!o_wb_ack) begin
            $display("read of address %0h got no ack within %0d clocks", adr, WB_TIMEOUT);
            errors++;
            dat = '0;
        end
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
    endtask

    // Pops one sample and compares it with the oldest model frame
    task automatic read_sample();
        logic [31:0] dat;
        logic [23:0] exp;
        read_reg(ADDR_DATA, dat);
        if (exp_q.size() == 0) begin
            $display("sample read back with no frame seen on the SPI bus");
            errors++;
        end else begin
            exp = exp_q.pop_front();
            check_value("o_wb_dat", dat, {8'h00, exp});
        end
    endtask

    task automatic wait_level();
        logic [31:0] st;
        int          level;
        int          n;
        n     = 0;
        level = 0;
        while (level == 0 && n < LEVEL_POLLS) begin
            read_reg(ADDR_STATUS, st);
            level = int'(st[7:0]);
            n++;
        end
        if (level == 0) begin
            $display("FIFO still empty after %0d status polls", LEVEL_POLLS);
            errors++;
        end
    endtask

    task automatic wait_frames(input int target);
        int n;
        n = 0;
        while (frame_cnt < target && n < FRAME_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (frame_cnt < target) begin
            $display("only %0d of %0d frames seen within %0d clocks",
                     frame_cnt, target, FRAME_TIMEOUT);
            errors++;
        end
    endtask

    // CS high for 8 clocks in a row means the frame and its store are done
    task automatic wait_idle();
        int quiet;
        int n;
        quiet = 0;
        n     = 0;
        while (quiet < 8 && n < IDLE_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
            quiet = o_cs_n ? quiet + 1 : 0;
        end
        if (quiet < 8) begin
            $display("chip select did not return high within %0d clocks", IDLE_TIMEOUT);
            errors++;
        end
    endtask

    task automatic drain_fifo();
        logic [31:0] st;
        read_reg(ADDR_STATUS, st);
        repeat (int'(st[7:0])) begin
            read_sample();
        end
        if (exp_q.size() != 0) begin
            $display("%0d frames on the SPI bus never reached the FIFO", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    initial begin
        logic [31:0] rd;
        logic [15:0] per;
        logic [7:0]  cmd;
        int          err0;
        int          start;
        void'($urandom(32'h8cfb));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        frame_cnt    = 0;
        model_seq    = '0;
        model_cmd    = '0;
        i_arst_n     = 1'b0;
        i_wb_cyc     = 1'b0;
        i_wb_stb     = 1'b0;
        i_wb_we      = 1'b0;
        i_wb_adr     = '0;
        i_wb_dat     = '0;
        repeat (2) @(posedge clk);
        #1;
        i_arst_n = 1'b1;

        // Reset values and no frame while disabled
        err0 = errors;
        check_value("o_sclk", 32'(o_sclk), 32'h0);
        check_value("o_mosi", 32'(o_mosi), 32'h0);
        read_reg(ADDR_CTRL, rd);
        check_value("o_wb_dat (CTRL)", rd, 32'h0);
        read_reg(ADDR_PERIOD, rd);
        check_value("o_wb_dat (PERIOD)", rd, 32'(PERIOD_RST));
        read_reg(ADDR_STATUS, rd);
        check_value("o_wb_dat (STATUS)", rd, 32'h0);
        repeat (200) @(posedge clk);
        #1;
        check_value("o_cs_n", 32'(o_cs_n), 32'h1);
        check_value("frame count", frame_cnt, 0);
        end_test("reset", err0);

        // Register write and read back
        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            per = 16'($urandom);
            cmd = 8'($urandom);
            write_reg(ADDR_PERIOD, 32'(per));
            read_reg(ADDR_PERIOD, rd);
            check_value("o_wb_dat (PERIOD)", rd, 32'(per));
            write_reg(ADDR_CTRL, {16'h0, cmd, 8'h00});
            read_reg(ADDR_CTRL, rd);
            check_value("o_wb_dat (CTRL)", rd, {16'h0, cmd, 8'h00});
        end
        end_test("registers", err0);

        // Streaming while the host keeps up with the frames
        err0      = errors;
        model_cmd = 8'($urandom);
        write_reg(ADDR_PERIOD, 32'(20 + $urandom % 40));
        write_reg(ADDR_CTRL, {16'h0, model_cmd, 8'h01});
        read_reg(ADDR_CTRL, rd);
        check_value("o_wb_dat (CTRL)", rd, {16'h0, model_cmd, 8'h01});
        for (int i = 0; i < 20; i++) begin
            wait_level();
            read_sample();
        end
        write_reg(ADDR_CTRL, {16'h0, model_cmd, 8'h00});
        wait_idle();
        drain_fifo();
        end_test("stream", err0);

        // Overrun with the host idle and 12 frames into 8 entries
        err0  = errors;
        start = frame_cnt;
        write_reg(ADDR_PERIOD, 32'd30);
        write_reg(ADDR_CTRL, {16'h0, model_cmd, 8'h01});
        wait_frames(start + 12);
        write_reg(ADDR_CTRL, {16'h0, model_cmd, 8'h00});
        wait_idle();
        read_reg(ADDR_STATUS, rd);
        check_value("o_wb_dat (STATUS)", rd, 32'h0000_0408);
        repeat (8) read_sample();
        read_reg(ADDR_DATA, rd);
        check_value("o_wb_dat (DATA empty)", rd, 32'h0);
        check_value("dropped frames", exp_q.size(), 4);
        exp_q.delete();
        end_test("overrun", err0);

        // Disable in the middle of a frame
        err0  = errors;
        start = frame_cnt;
        write_reg(ADDR_PERIOD, 32'd40);
        write_reg(ADDR_CTRL, {16'h0, model_cmd, 8'h01});
        wait_frames(start + 1);
        repeat (6) @(posedge clk);
        #1;
        check_value("o_cs_n", 32'(o_cs_n), 32'h0);
        write_reg(ADDR_CTRL, {16'h0, model_cmd, 8'h00});
        wait_idle();
        read_reg(ADDR_STATUS, rd);
        check_value("o_wb_dat (STATUS)", rd, 32'h0000_0401);
        read_sample();
        start = frame_cnt;
        repeat (5 * (40 + 80)) @(posedge clk);
        #1;
        check_value("frame count", frame_cnt, start);
        end_test("disable", err0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* testbench/spi_sampler_asserts.sv */
`timescale 1ns/1ps

module spi_sampler_asserts (
    input logic clk,
    input logic i_arst_n,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic o_wb_ack,
    input logic o_sclk,
    input logic o_mosi,
    input logic o_cs_n
);

    // Ack is a single-clock pulse
    ack_one_clock: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_wb_ack |=> !o_wb_ack)
        else $error("ack held high for more than one clock");

    // Ack answers a request seen on the clock before
    ack_needs_req: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
        else $error("ack given without cyc and stb");

    // Mode 0 idle level
    sclk_idle_low: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_cs_n |-> !o_sclk)
        else $error("sclk high while cs is released");

    // Data held through the high phase
    mosi_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_sclk |-> $stable(o_mosi))
        else $error("mosi changed while sclk was high");

endmodule

bind spi_sampler_top spi_sampler_asserts u_asserts (
    .clk     (clk),
    .i_arst_n(i_arst_n),
    .i_wb_cyc(i_wb_cyc),
    .i_wb_stb(i_wb_stb),
    .o_wb_ack(o_wb_ack),
    .o_sclk  (o_sclk),
    .o_mosi  (o_mosi),
    .o_cs_n  (o_cs_n)
);

/* hw/spi_sampler_top.sv */
`timescale 1ns/1ps

module spi_sampler_top import spi_sampler_pkg::*, wb_regs_pkg::*; #(
    parameter int CLKS_PER_HALF_BIT = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic             i_wb_cyc,
    input  logic             i_wb_stb,
    input  logic             i_wb_we,
    input  logic [WB_AW-1:0] i_wb_adr,
    input  logic [WB_DW-1:0] i_wb_dat,
    output logic [WB_DW-1:0] o_wb_dat,
    output logic             o_wb_ack,
    output logic             o_sclk,
    output logic             o_mosi,
    output logic             o_cs_n,
    input  logic             i_miso
);

    // Register outputs
    logic                        enable;
    logic [PERIOD_W-1:0]         period;
    logic [CMD_W-1:0]            cmd;

    // FIFO wiring
    logic                        push;
    sample_t                     push_data;
    logic                        pop;
    sample_t                     head;
    logic                        fifo_full;
    logic                        fifo_empty;
    logic [$clog2(FIFO_DEPTH):0] level;
    logic [OVR_W-1:0]            overrun_cnt;

    // Byte channel between controller and SPI engine
    spi_byte_if u_byte_if ();

    spi_master #(
        .CLKS_PER_HALF_BIT(CLKS_PER_HALF_BIT)
    ) u_spi_master (
        .clk     (clk),
        .i_arst_n(i_arst_n),
        .bus     (u_byte_if.master),
        .o_sclk  (o_sclk),
        .o_mosi  (o_mosi),
        .o_cs_n  (o_cs_n),
        .i_miso  (i_miso)
    );

    sampler_ctrl u_ctrl (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_enable     (enable),
        .i_period     (period),
        .i_cmd        (cmd),
        .bus          (u_byte_if.ctrl),
        .i_fifo_full  (fifo_full),
        .o_push       (push),
        .o_push_data  (push_data),
        .o_overrun_cnt(overrun_cnt)
    );

    sample_fifo #(
        .payload_t (sample_t),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_push     (push),
        .i_push_data(push_data),
        .i_pop      (pop),
        .o_head     (head),
        .o_full     (fifo_full),
        .o_empty    (fifo_empty),
        .o_level    (level)
    );

    wb_regs #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_regs (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_we      (i_wb_we),
        .i_wb_adr     (i_wb_adr),
        .i_wb_dat     (i_wb_dat),
        .o_wb_dat     (o_wb_dat),
        .o_wb_ack     (o_wb_ack),
        .o_enable     (enable),
        .o_period     (period),
        .o_cmd        (cmd),
        .i_level      (level),
        .i_overrun_cnt(overrun_cnt),
        .i_fifo_empty (fifo_empty),
        .i_head       (head),
        .o_pop        (pop)
    );

endmodule

/* hw/wb_regs.sv */
`timescale 1ns/1ps

module wb_regs import spi_sampler_pkg::*, wb_regs_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  logic                        i_wb_cyc,
    input  logic                        i_wb_stb,
    input  logic                        i_wb_we,
    input  logic [WB_AW-1:0]            i_wb_adr,
    input  logic [WB_DW-1:0]            i_wb_dat,
    output logic [WB_DW-1:0]            o_wb_dat,
    output logic                        o_wb_ack,
    output logic                        o_enable,
    output logic [PERIOD_W-1:0]         o_period,
    output logic [CMD_W-1:0]            o_cmd,
    input  logic [$clog2(FIFO_DEPTH):0] i_level,
    input  logic [OVR_W-1:0]            i_overrun_cnt,
    input  logic                        i_fifo_empty,
    input  sample_t                     i_head,
    output logic                        o_pop
);

    logic             req;
    logic [WB_DW-1:0] rd_data;

    // New cycle seen, ack follows on the next clock
    assign req   = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign o_pop = req && !i_wb_we && (i_wb_adr == ADDR_DATA) && !i_fifo_empty;

    // Read mux
    always_comb begin
        rd_data = '0;
        case (i_wb_adr)
            ADDR_CTRL: begin
                rd_data[CTRL_EN_BIT] = o_enable;
                rd_data[CTRL_CMD_LSB +: CMD_W] = o_cmd;
            end
            ADDR_PERIOD: rd_data[PERIOD_W-1:0] = o_period;
            ADDR_STATUS: begin
                rd_data[7:0] = 8'(i_level);
                rd_data[STAT_OVR_LSB +: OVR_W] = i_overrun_cnt;
            end
            // Empty FIFO reads back zero
            ADDR_DATA: begin
                if (!i_fifo_empty) begin
                    rd_data[$bits(sample_t)-1:0] = i_head;
                end
            end
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_ack <= 1'b0;
            o_enable <= 1'b0;
            o_cmd    <= '0;
            o_period <= PERIOD_W'(PERIOD_RST);
        end else begin
            o_wb_ack <= req;
            if (req && i_wb_we) begin
                if (i_wb_adr == ADDR_CTRL) begin
                    o_enable <= i_wb_dat[CTRL_EN_BIT];
                    o_cmd    <= i_wb_dat[CTRL_CMD_LSB +: CMD_W];
                end
                if (i_wb_adr == ADDR_PERIOD) begin
                    o_period <= i_wb_dat[PERIOD_W-1:0];
                end
            end
        end
    end

    // Read data lands together with ack
    always_ff @(posedge clk) begin
        if (req) begin
            o_wb_dat <= rd_data;
        end
    end

endmodule

/* hw/sampler_ctrl.sv */
`timescale 1ns/1ps

module sampler_ctrl import spi_sampler_pkg::*; (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic                i_enable,
    input  logic [PERIOD_W-1:0] i_period,
    input  logic [CMD_W-1:0]    i_cmd,
    spi_byte_if.ctrl            bus,
    input  logic                i_fifo_full,
    output logic                o_push,
    output sample_t             o_push_data,
    output logic [OVR_W-1:0]    o_overrun_cnt
);

    typedef enum logic [2:0] {IDLE, WAIT_PERIOD, BYTE_HI, BYTE_LO, STORE} state_t;

    state_t              state;
    logic [PERIOD_W-1:0] wait_cnt;
    logic [PERIOD_W:0]   wait_nxt;
    logic                frame_start;
    logic                tx_dv_q;
    logic [CMD_W-1:0]    tx_byte_q;
    logic                tx_last_q;
    logic [SAMPLE_W-1:0] word;
    logic [SEQ_W-1:0]    seq;

    // Period elapses after i_period clocks in WAIT_PERIOD
    assign wait_nxt    = {1'b0, wait_cnt} + 1'b1;
    assign frame_start = (state == WAIT_PERIOD) && i_enable && (wait_nxt >= {1'b0, i_period});

    assign bus.tx_dv   = tx_dv_q;
    assign bus.tx_byte = tx_byte_q;
    assign bus.tx_last = tx_last_q;

    // Dropped when full, the seq still moves on
    assign o_push      = (state == STORE) && !i_fifo_full;
    assign o_push_data = '{seq: seq, data: word};

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state         <= IDLE;
            wait_cnt      <= '0;
            tx_dv_q       <= 1'b0;
            seq           <= '0;
            o_overrun_cnt <= '0;
        end else begin
            // Request drops once the engine takes it
            if (tx_dv_q && bus.tx_ready) begin
                tx_dv_q <= 1'b0;
            end
            case (state)
                IDLE: begin
                    wait_cnt <= '0;
                    if (i_enable) begin
                        state <= WAIT_PERIOD;
                    end
                end
                WAIT_PERIOD: begin
                    wait_cnt <= wait_nxt[PERIOD_W-1:0];
                    if (!i_enable) begin
                        state <= IDLE;
                    end else if (frame_start) begin
                        tx_dv_q <= 1'b1;
                        state   <= BYTE_HI;
                    end
                end
                BYTE_HI: begin
                    // Command byte done, send the fill byte
                    if (bus.rx_dv) begin
                        tx_dv_q <= 1'b1;
                        state   <= BYTE_LO;
                    end
                end
                BYTE_LO: begin
                    if (bus.rx_dv) begin
                        state <= STORE;
                    end
                end
                STORE: begin
                    seq      <= seq + 1'b1;
                    wait_cnt <= '0;
                    if (i_fifo_full && o_overrun_cnt != '1) begin
                        o_overrun_cnt <= o_overrun_cnt + 1'b1;
                    end
                    // Disable only honored here, between frames
                    state <= i_enable ? WAIT_PERIOD : IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Byte requests and sample assembly, MSB byte first
    always_ff @(posedge clk) begin
        if (frame_start) begin
            tx_byte_q <= i_cmd;
            tx_last_q <= 1'b0;
        end else if (state == BYTE_HI && bus.rx_dv) begin
            tx_byte_q <= CMD_FILL;
            tx_last_q <= 1'b1;
        end
        if (state == BYTE_HI && bus.rx_dv) begin
            word[SAMPLE_W-1:CMD_W] <= bus.rx_byte;
        end
        if (state == BYTE_LO && bus.rx_dv) begin
            word[CMD_W-1:0] <= bus.rx_byte;
        end
    end

endmodule

/* hw/sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  FIFO_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  logic                        i_push,
    input  payload_t                    i_push_data,
    input  logic                        i_pop,
    output payload_t                    o_head,
    output logic                        o_full,
    output logic                        o_empty,
    output logic [$clog2(FIFO_DEPTH):0] o_level
);

    localparam int AW = $clog2(FIFO_DEPTH);

    payload_t      mem [FIFO_DEPTH];
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic          do_push;
    logic          do_pop;

    // Extra MSB on the pointers tells full from empty
    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign o_level = wr_ptr - rd_ptr;

    // Out-of-range requests are ignored
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    // Head word shows without a pop
    assign o_head = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= i_push_data;
        end
    end

endmodule

/* hw/spi_master.sv */
`timescale 1ns/1ps

module spi_master import spi_sampler_pkg::*; #(
    parameter int CLKS_PER_HALF_BIT = 4
) (
    input  logic       clk,
    input  logic       i_arst_n,
    spi_byte_if.master bus,
    output logic       o_sclk,
    output logic       o_mosi,
    output logic       o_cs_n,
    input  logic       i_miso
);

    localparam int HALF_W = $clog2(CLKS_PER_HALF_BIT) + 1;
    localparam int EDGES = 2 * CMD_W;
    localparam int EDGE_W = $clog2(EDGES);
    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(CLKS_PER_HALF_BIT - 1);
    localparam logic [EDGE_W-1:0] EDGE_LAST = EDGE_W'(EDGES - 1);

    typedef enum logic [1:0] {ST_IDLE, ST_XFER, ST_DONE, ST_HOLD} state_t;

    state_t           state;
    logic [HALF_W-1:0] half_cnt;
    logic [EDGE_W-1:0] edge_cnt;
    logic [CMD_W-1:0]  tx_shift;
    logic [CMD_W-1:0]  rx_shift;
    logic [CMD_W-1:0]  rx_byte_q;
    logic              last_q;
    logic              tx_ready_q;
    logic              rx_dv_q;
    logic              half_end;
    logic              accept;

    // End of one half SCLK period
    assign half_end = (half_cnt == HALF_LAST);
    assign accept   = (state == ST_IDLE) && bus.tx_dv && tx_ready_q;

    assign bus.tx_ready = tx_ready_q;
    assign bus.rx_dv    = rx_dv_q;
    assign bus.rx_byte  = rx_byte_q;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state      <= ST_IDLE;
            half_cnt   <= '0;
            edge_cnt   <= '0;
            o_sclk     <= 1'b0;
            o_mosi     <= 1'b0;
            o_cs_n     <= 1'b1;
            tx_ready_q <= 1'b1;
            rx_dv_q    <= 1'b0;
        end else begin
            rx_dv_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // MSB is on MOSI before the first rising edge
                    if (accept) begin
                        tx_ready_q <= 1'b0;
                        o_cs_n     <= 1'b0;
                        o_mosi     <= bus.tx_byte[CMD_W-1];
                        half_cnt   <= '0;
                        edge_cnt   <= '0;
                        state      <= ST_XFER;
                    end
                end
                ST_XFER: begin
                    half_cnt <= half_end ? '0 : half_cnt + 1'b1;
                    if (half_end) begin
                        o_sclk   <= ~o_sclk;
                        edge_cnt <= edge_cnt + 1'b1;
                        // Falling edge shifts the next bit out
                        if (o_sclk) begin
                            o_mosi <= tx_shift[CMD_W-2];
                        end
                        if (edge_cnt == EDGE_LAST) begin
                            state <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    rx_dv_q  <= 1'b1;
                    half_cnt <= '0;
                    if (last_q) begin
                        state <= ST_HOLD;
                    end else begin
                        // CS stays low between bytes of one frame
                        tx_ready_q <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                ST_HOLD: begin
                    // Half bit of CS hold after the last SCLK edge
                    half_cnt <= half_cnt + 1'b1;
                    if (half_end) begin
                        o_cs_n     <= 1'b1;
                        o_mosi     <= 1'b0;
                        tx_ready_q <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Shift registers and captured byte
    always_ff @(posedge clk) begin
        if (accept) begin
            tx_shift <= bus.tx_byte;
            last_q   <= bus.tx_last;
        end else if (state == ST_XFER && half_end && o_sclk) begin
            tx_shift <= {tx_shift[CMD_W-2:0], 1'b0};
        end
        // MISO sampled as SCLK rises
        if (state == ST_XFER && half_end && !o_sclk) begin
            rx_shift <= {rx_shift[CMD_W-2:0], i_miso};
        end
        if (state == ST_DONE) begin
            rx_byte_q <= rx_shift;
        end
    end

endmodule

/* hw/spi_byte_if.sv */
`timescale 1ns/1ps

interface spi_byte_if import spi_sampler_pkg::*; ();

    // Request side, from the controller
    logic             tx_dv;
    logic [CMD_W-1:0] tx_byte;
    logic             tx_last;

    // Engine side, back to the controller
    logic             tx_ready;
    logic             rx_dv;
    logic [CMD_W-1:0] rx_byte;

    modport ctrl (
        output tx_dv, tx_byte, tx_last,
        input  tx_ready, rx_dv, rx_byte
    );

    modport master (
        input  tx_dv, tx_byte, tx_last,
        output tx_ready, rx_dv, rx_byte
    );

endinterface

/* hw/wb_regs_pkg.sv */
package wb_regs_pkg;

    // Bus widths, word addressed
    localparam int WB_AW = 4;
    localparam int WB_DW = 32;

    // Register map
    localparam logic [WB_AW-1:0] ADDR_CTRL   = 4'h0;
    localparam logic [WB_AW-1:0] ADDR_PERIOD = 4'h1;
    localparam logic [WB_AW-1:0] ADDR_STATUS = 4'h2;
    localparam logic [WB_AW-1:0] ADDR_DATA   = 4'h3;

    // Field positions
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_CMD_LSB = 8;
    localparam int STAT_OVR_LSB = 8;

    // Period after reset, in clocks
    localparam int PERIOD_RST = 1000;

endpackage

/* hw/spi_sampler_pkg.sv */
package spi_sampler_pkg;

    // Command byte and SPI byte width
    localparam int CMD_W = 8;

    // Assembled sample word, MSB byte first on the wire
    localparam int SAMPLE_W = 16;

    // Sequence tag carried with every sample
    localparam int SEQ_W = 8;

    // Sample period counter width, in clocks
    localparam int PERIOD_W = 16;

    // Overrun counter width, saturating
    localparam int OVR_W = 8;

    // Second byte of a frame, clocked out while the low data byte comes in
    localparam logic [CMD_W-1:0] CMD_FILL = 8'h00;

    // One stored sample, seq in the upper byte
    typedef struct packed {
        logic [SEQ_W-1:0]    seq;
        logic [SAMPLE_W-1:0] data;
    } sample_t;

endpackage
